//--- verilog/tiny86_pkg.sv
`default_nettype none

package tiny86_pkg;

    // --------------------
    // widths
    // --------------------

    typedef logic [15:0] addr_t; // byte address on the memory bus.
    typedef logic [7:0] byte_t;
    typedef logic [15:0] word_t;
    typedef logic [2:0] reg_idx_t; // register number in 8086 encoding order.

    // --------------------
    // register numbers
    // --------------------

    localparam reg_idx_t reg_ax = 3'd0;
    localparam reg_idx_t reg_cx = 3'd1;

    // --------------------
    // operations and states
    // --------------------

    typedef enum logic [3:0] {
        op_mov_imm,
        op_inc,
        op_dec,
        op_add_ax,
        op_load_al,
        op_store_al,
        op_store_ax,
        op_jmp,
        op_jnz,
        op_hlt,
        op_invalid
    } op_t;

    // The sequencer walks fetch, operands, an optional memory access and execute.
    typedef enum logic [2:0] {
        st_fetch,
        st_operand,
        st_exec,
        st_mem,
        st_halt
    } seq_state_t;

endpackage

`default_nettype wire

//--- verilog/tiny86_ifs.sv
`default_nettype none

// one byte request from the sequencer to the bus unit.
interface mem_req_if import tiny86_pkg::*; ();
    logic req; // single-cycle strobe.
    logic we;
    addr_t addr;
    byte_t wdata;
    logic done; // single-cycle strobe.
    byte_t rdata;

    modport requester (output req, we, addr, wdata, input done, rdata);
    modport server (input req, we, addr, wdata, output done, rdata);
endinterface

// register file access from the sequencer.
interface reg_if import tiny86_pkg::*; ();
    reg_idx_t rd_sel;
    word_t rd_data;
    logic wr_en;
    reg_idx_t wr_sel;
    logic [1:0] wr_byte_en; // bit 0 writes the low byte, bit 1 the high byte.
    word_t wr_data;

    modport user (
        output rd_sel, wr_en, wr_sel, wr_byte_en, wr_data,
        input rd_data
    );
    modport store (
        input rd_sel, wr_en, wr_sel, wr_byte_en, wr_data,
        output rd_data
    );
endinterface

`default_nettype wire

//--- verilog/opcode_decoder.sv
`default_nettype none

module opcode_decoder import tiny86_pkg::*; (
    input byte_t opcode,
    output op_t op,
    output logic [1:0] operand_count,
    output reg_idx_t op_reg
);

    assign op_reg = opcode[2:0]; // only meaningful for the register ranges.

    always_comb begin
        op = op_invalid;
        operand_count = 2'd0;
        casez (opcode)
            8'b1011_1???: begin // B8 to BF.
                op = op_mov_imm;
                operand_count = 2'd2;
            end
            8'b0100_0???: begin // 40 to 47.
                op = op_inc;
            end
            8'b0100_1???: begin // 48 to 4F.
                op = op_dec;
            end
            8'h05: begin
                op = op_add_ax;
                operand_count = 2'd2;
            end
            8'ha0: begin
                op = op_load_al;
                operand_count = 2'd2;
            end
            8'ha2: begin
                op = op_store_al;
                operand_count = 2'd2;
            end
            8'ha3: begin
                op = op_store_ax;
                operand_count = 2'd2;
            end
            8'heb: begin
                op = op_jmp;
                operand_count = 2'd1;
            end
            8'h75: begin
                op = op_jnz;
                operand_count = 2'd1;
            end
            8'hf4: begin
                op = op_hlt;
            end
            default: begin
                op = op_invalid;
                operand_count = 2'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`default_nettype none

module register_file import tiny86_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    reg_if.store regs
);

    word_t registers [0:7];

    assign regs.rd_data = registers[regs.rd_sel];

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < 8; i++) begin
                registers[i] <= '0;
            end
        end else if (regs.wr_en) begin
            if (regs.wr_byte_en[0]) begin
                registers[regs.wr_sel][7:0] <= regs.wr_data[7:0];
            end
            if (regs.wr_byte_en[1]) begin
                registers[regs.wr_sel][15:8] <= regs.wr_data[15:8];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/bus_unit.sv
`default_nettype none

module bus_unit import tiny86_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    mem_req_if.server mem,
    output addr_t address,
    input wire byte_t data_in,
    output byte_t data_out,
    output logic rd,
    output logic wr,
    input wire logic ready
);

    typedef enum logic {
        bus_idle,
        bus_wait
    } bus_state_t;

    bus_state_t state;

    // --------------------
    // bus cycle
    // --------------------

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= bus_idle;
            rd <= 1'b0;
            wr <= 1'b0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= 1'b0;
            case (state)
                bus_idle: begin
                    if (mem.req) begin
                        address <= mem.addr; // held until ready.
                        data_out <= mem.wdata;
                        rd <= !mem.we;
                        wr <= mem.we;
                        state <= bus_wait;
                    end
                end
                bus_wait: begin
                    if (ready) begin
                        mem.rdata <= data_in;
                        rd <= 1'b0;
                        wr <= 1'b0;
                        mem.done <= 1'b1;
                        state <= bus_idle;
                    end
                end
                default: state <= bus_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/sequencer.sv
`default_nettype none

module sequencer import tiny86_pkg::*; #(
    parameter addr_t reset_vector = '0
) (
    input wire logic clk,
    input wire logic reset,
    mem_req_if.requester mem,
    reg_if.user regs,
    output byte_t opcode,
    input wire op_t op,
    input wire logic [1:0] operand_count,
    input wire reg_idx_t op_reg,
    output logic hlt,
    output logic error
);

    seq_state_t state;
    addr_t pc;
    logic busy; // a request is outstanding.
    logic zero;
    byte_t opcode_q;
    word_t imm_q; // operand bytes, little-endian.
    byte_t load_q;
    logic [1:0] operand_idx;
    logic [1:0] operand_next;
    logic mem_hi; // second byte of a word store.

    logic is_mem_op;
    logic is_reg_write;
    word_t alu_result;
    addr_t rel_target;

    // --------------------
    // decode helpers
    // --------------------

    // The decoder sees the fetched byte in the cycle it arrives.
    assign opcode = (state == st_fetch && mem.done) ? mem.rdata : opcode_q;

    assign operand_next = operand_idx + 2'd1;
    assign is_mem_op = (op == op_load_al) || (op == op_store_al) || (op == op_store_ax);
    assign is_reg_write = (op == op_mov_imm) || (op == op_inc) || (op == op_dec)
        || (op == op_add_ax) || (op == op_load_al);

    assign rel_target = pc + {{8{imm_q[7]}}, imm_q[7:0]}; // pc already points past rel8.

    always_comb begin
        case (op)
            op_inc: alu_result = regs.rd_data + 16'd1;
            op_dec: alu_result = regs.rd_data - 16'd1;
            op_add_ax: alu_result = regs.rd_data + imm_q;
            default: alu_result = imm_q;
        endcase
    end

    // --------------------
    // register access
    // --------------------

    assign regs.rd_sel = (op == op_inc || op == op_dec) ? op_reg : reg_ax;

    always_comb begin
        regs.wr_en = (state == st_exec) && is_reg_write;
        regs.wr_sel = (op == op_add_ax || op == op_load_al) ? reg_ax : op_reg;
        regs.wr_byte_en = (op == op_load_al) ? 2'b01 : 2'b11;
        regs.wr_data = (op == op_load_al) ? {8'h00, load_q} : alu_result;
    end

    // --------------------
    // state machine
    // --------------------

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= st_fetch;
            pc <= reset_vector;
            busy <= 1'b0;
            zero <= 1'b0;
            hlt <= 1'b0;
            error <= 1'b0;
            opcode_q <= '0;
            operand_idx <= '0;
            mem_hi <= 1'b0;
            mem.req <= 1'b0;
        end else begin
            mem.req <= 1'b0;
            case (state)
                st_fetch: begin
                    if (!busy) begin
                        mem.req <= 1'b1;
                        mem.we <= 1'b0;
                        mem.addr <= pc;
                        busy <= 1'b1;
                    end else if (mem.done) begin
                        busy <= 1'b0;
                        opcode_q <= mem.rdata;
                        pc <= pc + 16'd1;
                        operand_idx <= '0;
                        state <= (operand_count == 2'd0) ? st_exec : st_operand;
                    end
                end
                st_operand: begin
                    if (!busy) begin
                        mem.req <= 1'b1;
                        mem.we <= 1'b0;
                        mem.addr <= pc;
                        busy <= 1'b1;
                    end else if (mem.done) begin
                        busy <= 1'b0;
                        pc <= pc + 16'd1;
                        if (operand_idx[0]) begin
                            imm_q[15:8] <= mem.rdata;
                        end else begin
                            imm_q[7:0] <= mem.rdata;
                        end
                        operand_idx <= operand_next;
                        if (operand_next == operand_count) begin
                            state <= is_mem_op ? st_mem : st_exec;
                        end
                    end
                end
                st_mem: begin
                    if (!busy) begin
                        mem.req <= 1'b1;
                        mem.we <= (op != op_load_al);
                        mem.addr <= imm_q + {15'd0, mem_hi};
                        mem.wdata <= mem_hi ? regs.rd_data[15:8] : regs.rd_data[7:0];
                        busy <= 1'b1;
                    end else if (mem.done) begin
                        busy <= 1'b0;
                        load_q <= mem.rdata;
                        if (op == op_store_ax && !mem_hi) begin
                            mem_hi <= 1'b1; // high byte goes out next.
                        end else begin
                            mem_hi <= 1'b0;
                            state <= st_exec;
                        end
                    end
                end
                st_exec: begin
                    state <= st_fetch;
                    case (op)
                        op_inc, op_dec, op_add_ax: zero <= (alu_result == 16'd0);
                        op_jmp: pc <= rel_target;
                        op_jnz: begin
                            if (!zero) begin
                                pc <= rel_target;
                            end
                        end
                        op_hlt: begin
                            hlt <= 1'b1;
                            state <= st_halt;
                        end
                        op_invalid: begin
                            hlt <= 1'b1;
                            error <= 1'b1;
                            state <= st_halt;
                        end
                        default: begin
                        end
                    endcase
                end
                st_halt: begin
                    state <= st_halt; // only reset leaves this state.
                end
                default: state <= st_halt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/tiny86_top.sv
`default_nettype none

module tiny86_top import tiny86_pkg::*; #(
    parameter addr_t reset_vector = '0
) (
    input wire logic clk,
    input wire logic reset,
    output logic hlt,
    output logic error,
    output addr_t address,
    input wire byte_t data_in,
    output byte_t data_out,
    output logic rd,
    output logic wr,
    input wire logic ready
);

    byte_t opcode;
    op_t op;
    logic [1:0] operand_count;
    reg_idx_t op_reg;

    mem_req_if mem ();
    reg_if regs ();

    sequencer #(
        .reset_vector(reset_vector)
    ) u_sequencer (
        .clk(clk),
        .reset(reset),
        .mem(mem.requester),
        .regs(regs.user),
        .opcode(opcode),
        .op(op),
        .operand_count(operand_count),
        .op_reg(op_reg),
        .hlt(hlt),
        .error(error)
    );

    opcode_decoder u_decoder (
        .opcode(opcode),
        .op(op),
        .operand_count(operand_count),
        .op_reg(op_reg)
    );

    register_file u_register_file (
        .clk(clk),
        .reset(reset),
        .regs(regs.store)
    );

    bus_unit u_bus_unit (
        .clk(clk),
        .reset(reset),
        .mem(mem.server),
        .address(address),
        .data_in(data_in),
        .data_out(data_out),
        .rd(rd),
        .wr(wr),
        .ready(ready)
    );

endmodule

`default_nettype wire

//--- testbench/tiny86_assert.sv
`default_nettype none

module tiny86_assert import tiny86_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic rd,
    input wire logic wr,
    input wire logic ready,
    input wire addr_t address,
    input wire byte_t data_out,
    input wire seq_state_t state
);

    int failures = 0; // read by the testbench at the end of the run.

    a_exclusive: assert property (@(posedge clk) disable iff (!reset) !(rd && wr))
        else begin
            failures++;
            $error("rd and wr are high together");
        end

    // a waiting bus cycle keeps its strobe, address and data.
    a_stable: assert property (@(posedge clk) disable iff (!reset)
        (rd || wr) && !ready |=> $stable(rd) && $stable(wr) && $stable(address)
            && $stable(data_out))
        else begin
            failures++;
            $error("bus signals changed while waiting for ready");
        end

    a_halt_idle: assert property (@(posedge clk) disable iff (!reset)
        (state == st_halt) |-> !rd && !wr)
        else begin
            failures++;
            $error("bus cycle active after halt");
        end

    a_reset_idle: assert property (@(posedge clk) !reset |=> !rd && !wr)
        else begin
            failures++;
            $error("rd or wr high after reset");
        end

endmodule

bind tiny86_top tiny86_assert u_assert (
    .clk(clk),
    .reset(reset),
    .rd(rd),
    .wr(wr),
    .ready(ready),
    .address(address),
    .data_out(data_out),
    .state(u_sequencer.state)
);

`default_nettype wire

//--- testbench/tiny86_tb.sv
`default_nettype none

module tiny86_tb import tiny86_pkg::*; ();

    logic clk, reset, ready, hlt, error, rd, wr;
    byte_t data_in, data_out;
    addr_t address;

    byte_t mem [0:65535];
    addr_t log_addr [0:63];
    byte_t log_data [0:63];
    addr_t exp_addr [0:63];
    byte_t exp_data [0:63];
    int log_n, exp_n, prog_len, errors, checks, wait_left;
    logic random_waits, in_cycle;
    logic [31:0] rng_state;

    tiny86_top dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // --------------------
    // memory model
    // --------------------

    always @(posedge clk) begin
        #1;
        if (rd || wr) begin
            if (!in_cycle) begin
                in_cycle = 1'b1;
                rng_state = xorshift(rng_state);
                wait_left = random_waits ? int'(rng_state[1:0]) : 0; // 0 to 3 waits.
            end
        end else begin
            in_cycle = 1'b0;
        end
        ready = in_cycle && (wait_left == 0);
        if (in_cycle && wait_left != 0) begin
            wait_left = wait_left - 1;
        end
        data_in = mem[address];
    end

    // the write completes at the next edge.
    always @(negedge clk) begin
        if (reset && wr && ready && log_n < 64) begin
            log_addr[log_n] = address;
            log_data[log_n] = data_out;
            mem[address] = data_out;
            log_n++;
        end
    end

    // --------------------
    // helpers
    // --------------------

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic report_and_finish();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.u_assert.failures);
        if (errors == 0 && dut.u_assert.failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic start_test();
        for (int a = 0; a < 65536; a++) begin
            mem[a] = a[15:8] ^ a[7:0] ^ 8'h5a;
        end
        prog_len = 0;
        log_n = 0;
        exp_n = 0;
    endtask

    task automatic emit(input byte_t b);
        mem[prog_len] = b;
        prog_len++;
    endtask

    task automatic emit_imm(input byte_t op, input word_t w);
        emit(op);
        emit(w[7:0]);
        emit(w[15:8]);
    endtask

    task automatic expect_write(input addr_t a, input byte_t d);
        exp_addr[exp_n] = a;
        exp_data[exp_n] = d;
        exp_n++;
    endtask

    task automatic expect_word(input addr_t a, input word_t w);
        expect_write(a, w[7:0]); // little-endian.
        expect_write(a + 16'd1, w[15:8]);
    endtask

    task automatic run_program(input string name, input logic exp_error);
        int limit;
        int cycles;
        limit = 20 * prog_len + 500;
        cycles = 0;
        @(posedge clk);
        #1 reset = 1'b0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b1;
        while (!hlt && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!hlt) begin
            errors++;
            $display("timeout: test %s did not halt within %0d cycles", name, limit);
            report_and_finish();
        end else begin
            repeat (4) @(negedge clk);
            check({name, " error"}, 32'(exp_error), 32'(error));
            check({name, " hlt"}, 32'd1, 32'(hlt));
            check({name, " write count"}, exp_n, log_n);
            for (int i = 0; i < exp_n && i < log_n; i++) begin
                check($sformatf("%s address[%0d]", name, i), 32'(exp_addr[i]),
                      32'(log_addr[i]));
                check($sformatf("%s data_out[%0d]", name, i), 32'(exp_data[i]),
                      32'(log_data[i]));
            end
        end
    endtask

    // --------------------
    // directed tests
    // --------------------

    // each register counts itself into ax through a dec/jnz loop.
    task automatic test_mov_store();
        start_test();
        emit_imm(8'hb8, 16'h1234);
        for (int r = 1; r < 8; r++) begin
            emit_imm(byte_t'(8'hb8 + r), word_t'(r));
        end
        emit_imm(8'ha3, 16'h0200);
        expect_word(16'h0200, 16'h1234);
        for (int r = 1; r < 8; r++) begin
            emit_imm(8'hb8, 16'h0000);
            emit(8'h40);
            emit(byte_t'(8'h48 + r));
            emit(8'h75);
            emit(8'hfc);
            emit_imm(8'ha3, addr_t'(16'h0200 + 2 * r));
            expect_word(addr_t'(16'h0200 + 2 * r), word_t'(r));
        end
        emit(8'hf4);
        run_program("mov_store", 1'b0);
    endtask

    task automatic test_arith();
        word_t w;
        start_test();
        w = 16'hfff0;
        w = w + 16'h0025;
        emit_imm(8'hb8, 16'hfff0);
        emit_imm(8'h05, 16'h0025);
        emit_imm(8'ha3, 16'h0300);
        expect_word(16'h0300, w);
        w = 16'hffff;
        w = w + 16'd1;
        emit_imm(8'hb8, 16'hffff);
        emit(8'h40);
        emit_imm(8'ha3, 16'h0302);
        expect_word(16'h0302, w);
        emit(8'h75); // zero is set so the store below still runs.
        emit(8'h03);
        emit_imm(8'ha3, 16'h0304);
        expect_word(16'h0304, w);
        w = w - 16'd1;
        emit(8'h48);
        emit_imm(8'ha3, 16'h0306);
        expect_word(16'h0306, w);
        emit(8'hf4);
        run_program("arith", 1'b0);
    endtask

    task automatic test_loops();
        start_test();
        emit_imm(8'hb9, 16'd5);
        emit_imm(8'hb8, 16'd0);
        emit(8'h40);
        emit(8'h49);
        emit(8'h75);
        emit(8'hfc);
        emit_imm(8'ha3, 16'h0400);
        expect_word(16'h0400, 16'd5);
        emit(8'heb);
        emit(8'h03);
        emit_imm(8'ha3, 16'h0410); // skipped by the jmp.
        emit(8'hf4);
        run_program("loops", 1'b0);
    endtask

    task automatic test_load();
        start_test();
        mem[16'h0500] = 8'h9c;
        emit_imm(8'hb8, 16'h7e11);
        emit_imm(8'ha0, 16'h0500);
        emit_imm(8'ha3, 16'h0502);
        expect_word(16'h0502, {8'h7e, 8'h9c});
        emit_imm(8'ha2, 16'h0504);
        expect_write(16'h0504, 8'h9c);
        emit(8'hf4);
        run_program("load", 1'b0);
    endtask

    task automatic test_invalid();
        start_test();
        emit_imm(8'hb8, 16'h0a0b);
        emit_imm(8'ha3, 16'h0600);
        expect_word(16'h0600, 16'h0a0b);
        emit(8'h0f);
        emit_imm(8'ha3, 16'h0602);
        emit(8'hf4);
        run_program("invalid", 1'b1);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b0;
        ready = 1'b0;
        data_in = '0;
        random_waits = 1'b0;
        in_cycle = 1'b0;
        wait_left = 0;
        rng_state = 32'h401f6564;
        errors = 0;
        checks = 0;
        // a second pass repeats every test with random wait states.
        for (int pass = 0; pass < 2; pass++) begin
            random_waits = (pass == 1);
            test_mov_store();
            test_arith();
            test_loops();
            test_load();
            test_invalid();
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/tiny86_pkg.sv
verilog/tiny86_ifs.sv
verilog/opcode_decoder.sv
verilog/register_file.sv
verilog/bus_unit.sv
verilog/sequencer.sv
verilog/tiny86_top.sv
testbench/tiny86_assert.sv
testbench/tiny86_tb.sv

//--- Bender.yml
package:
  name: tiny86

sources:
  - verilog/tiny86_pkg.sv
  - verilog/tiny86_ifs.sv
  - verilog/opcode_decoder.sv
  - verilog/register_file.sv
  - verilog/bus_unit.sv
  - verilog/sequencer.sv
  - verilog/tiny86_top.sv
  - target: test
    files:
      - testbench/tiny86_assert.sv
      - testbench/tiny86_tb.sv
